//--- include/la32_opcodes.svh
`ifndef LA32_OPCODES_SVH
`define LA32_OPCODES_SVH

// ##################################################
// 3R format with the opcode in instruction bits 31:15
// rk in 14:10, rj in 9:5, rd in 4:0
// ##################################################

localparam logic [16:0] OPC_ADD_W = 17'h00020; // add.w rd, rj, rk
localparam logic [16:0] OPC_SUB_W = 17'h00022; // sub.w rd, rj, rk
localparam logic [16:0] OPC_SLT   = 17'h00024; // Signed set-less-than
localparam logic [16:0] OPC_SLTU  = 17'h00025; // Unsigned set-less-than
localparam logic [16:0] OPC_AND   = 17'h00029;
localparam logic [16:0] OPC_OR    = 17'h0002a;
localparam logic [16:0] OPC_XOR   = 17'h0002b;

// ##################################################
// 2RI12 format with the opcode in instruction bits 31:22
// si12 in 21:10, rj in 9:5, rd in 4:0
// ##################################################

localparam logic [9:0]  OPC_ADDI_W = 10'h00a; // addi.w rd, rj, si12

`endif

//--- logic/core_pkg.sv
package core_pkg;

    `include "la32_opcodes.svh"

    // ##################################################
    // Width types
    // ##################################################

    typedef logic [31:0]        word_t;      // Register value, result or instruction
    typedef logic [4:0]         reg_addr_t;  // One of 32 architectural registers
    typedef logic signed [11:0] imm12_t;     // si12 field of the 2RI12 format

    // ##################################################
    // Internal ALU operation codes
    // ##################################################

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t OP_NOP  = 4'd0; // Retires without a register write
    localparam alu_op_t OP_ADD  = 4'd1;
    localparam alu_op_t OP_SUB  = 4'd2;
    localparam alu_op_t OP_SLT  = 4'd3;
    localparam alu_op_t OP_SLTU = 4'd4;
    localparam alu_op_t OP_AND  = 4'd5;
    localparam alu_op_t OP_OR   = 4'd6;
    localparam alu_op_t OP_XOR  = 4'd7;
    localparam alu_op_t OP_ADDI = 4'd8; // Second operand from the immediate

endpackage

//--- logic/decode_stage.sv
module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      issue_valid0,
    input  logic      issue_valid1,
    input  word_t     inst0,
    input  word_t     inst1,
    output logic      d_valid0,
    output logic      d_valid1,
    output alu_op_t   d_op0,
    output alu_op_t   d_op1,
    output reg_addr_t d_rj0,
    output reg_addr_t d_rj1,
    output reg_addr_t d_rk0,
    output reg_addr_t d_rk1,
    output reg_addr_t d_rd0,
    output reg_addr_t d_rd1,
    output imm12_t    d_imm0,
    output imm12_t    d_imm1
);

    alu_op_t op0;
    alu_op_t op1;

    // ##################################################
    // Opcode match
    // ##################################################

    function automatic alu_op_t decode_op(input word_t inst);
        alu_op_t op;
        op = OP_NOP;
        if (inst[31:22] == OPC_ADDI_W) begin
            op = OP_ADDI;
        end else begin
            case (inst[31:15])
                OPC_ADD_W: op = OP_ADD;
                OPC_SUB_W: op = OP_SUB;
                OPC_SLT:   op = OP_SLT;
                OPC_SLTU:  op = OP_SLTU;
                OPC_AND:   op = OP_AND;
                OPC_OR:    op = OP_OR;
                OPC_XOR:   op = OP_XOR;
                default:   op = OP_NOP; // Unknown encodings retire as no-ops
            endcase
        end
        return op;
    endfunction

    assign op0 = decode_op(inst0);
    assign op1 = decode_op(inst1);

    // ##################################################
    // Decode registers
    // ##################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            d_valid0 <= 1'b0;
            d_valid1 <= 1'b0;
            d_op0    <= OP_NOP;
            d_op1    <= OP_NOP;
        end else begin
            d_valid0 <= issue_valid0;
            d_valid1 <= issue_valid1;
            d_op0    <= issue_valid0 ? op0 : OP_NOP; // Empty lane never writes
            d_op1    <= issue_valid1 ? op1 : OP_NOP;
        end
    end

    // Register fields taken raw from both formats
    always_ff @(posedge clk) begin
        d_rj0  <= inst0[9:5];
        d_rk0  <= inst0[14:10];
        d_rd0  <= inst0[4:0];
        d_imm0 <= inst0[21:10];
        d_rj1  <= inst1[9:5];
        d_rk1  <= inst1[14:10];
        d_rd1  <= inst1[4:0];
        d_imm1 <= inst1[21:10];
    end

endmodule

//--- logic/execute_stage.sv
module execute_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      d_valid0,
    input  logic      d_valid1,
    input  alu_op_t   d_op0,
    input  alu_op_t   d_op1,
    input  reg_addr_t d_rj0,
    input  reg_addr_t d_rj1,
    input  reg_addr_t d_rk0,
    input  reg_addr_t d_rk1,
    input  reg_addr_t d_rd0,
    input  reg_addr_t d_rd1,
    input  imm12_t    d_imm0,
    input  imm12_t    d_imm1,
    input  word_t     rrj0,
    input  word_t     rrk0,
    input  word_t     rrj1,
    input  word_t     rrk1,
    output reg_addr_t rj0,
    output reg_addr_t rk0,
    output reg_addr_t rj1,
    output reg_addr_t rk1,
    output logic      ret_valid0,
    output logic      ret_valid1,
    output logic      ret_write0,
    output logic      ret_write1,
    output reg_addr_t ret_addr0,
    output reg_addr_t ret_addr1,
    output word_t     ret_data0,
    output word_t     ret_data1
);

    word_t opb0;
    word_t opb1;
    word_t res0;
    word_t res1;

    // Source numbers go straight to the register file read ports
    assign rj0 = d_rj0;
    assign rk0 = d_rk0;
    assign rj1 = d_rj1;
    assign rk1 = d_rk1;

    // ##################################################
    // Operand select and ALU
    // ##################################################

    function automatic word_t select_b(input alu_op_t op, input imm12_t imm, input word_t rk);
        word_t b;
        if (op == OP_ADDI) begin
            b = {{20{imm[11]}}, imm}; // si12 sign-extended
        end else begin
            b = rk;
        end
        return b;
    endfunction

    function automatic word_t alu(input alu_op_t op, input word_t a, input word_t b);
        word_t y;
        case (op)
            OP_ADD,
            OP_ADDI: y = a + b;
            OP_SUB:  y = a - b;
            OP_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU: y = {31'b0, a < b};
            OP_AND:  y = a & b;
            OP_OR:   y = a | b;
            OP_XOR:  y = a ^ b;
            default: y = '0; // No-op result is never written
        endcase
        return y;
    endfunction

    always_comb begin
        opb0 = select_b(d_op0, d_imm0, rrk0);
        opb1 = select_b(d_op1, d_imm1, rrk1);
        res0 = alu(d_op0, rrj0, opb0);
        res1 = alu(d_op1, rrj1, opb1);
    end

    // ##################################################
    // Retire and writeback latch
    // ##################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ret_valid0 <= 1'b0;
            ret_valid1 <= 1'b0;
            ret_write0 <= 1'b0;
            ret_write1 <= 1'b0;
        end else begin
            ret_valid0 <= d_valid0;
            ret_valid1 <= d_valid1;
            ret_write0 <= d_valid0 && (d_op0 != OP_NOP);
            ret_write1 <= d_valid1 && (d_op1 != OP_NOP);
        end
    end

    always_ff @(posedge clk) begin
        ret_addr0 <= d_rd0;
        ret_addr1 <= d_rd1;
        ret_data0 <= res0;
        ret_data1 <= res1;
    end

endmodule

//--- logic/register_file.sv
module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      ifwb0,
    input  logic      ifwb1,
    input  reg_addr_t wb_addr0,
    input  reg_addr_t wb_addr1,
    input  word_t     wb_data0,
    input  word_t     wb_data1,
    input  reg_addr_t rj0,
    input  reg_addr_t rk0,
    input  reg_addr_t rj1,
    input  reg_addr_t rk1,
    input  reg_addr_t dbg_addr,
    output word_t     rrj0,
    output word_t     rrk0,
    output word_t     rrj1,
    output word_t     rrk1,
    output word_t     dbg_data
);

    word_t rf [0:31];

    // ##################################################
    // Two write ports
    // ##################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (ifwb0 && (wb_addr0 != '0)) begin
                rf[wb_addr0] <= wb_data0;
            end
            // Later assignment wins, so lane 1 takes a shared address
            if (ifwb1 && (wb_addr1 != '0)) begin
                rf[wb_addr1] <= wb_data1;
            end
        end
    end

    // ##################################################
    // Read ports with bypass
    // ##################################################

    function automatic word_t read_port(input reg_addr_t addr);
        word_t d;
        if (addr == '0) begin
            d = '0; // r0 is hardwired
        end else if (ifwb1 && (addr == wb_addr1)) begin
            d = wb_data1;
        end else if (ifwb0 && (addr == wb_addr0)) begin
            d = wb_data0;
        end else begin
            d = rf[addr];
        end
        return d;
    endfunction

    always_comb begin
        rrj0 = read_port(rj0);
        rrk0 = read_port(rk0);
        rrj1 = read_port(rj1);
        rrk1 = read_port(rk1);
    end

    assign dbg_data = rf[dbg_addr]; // Raw array, no bypass

endmodule

//--- logic/dual_issue_core.sv
module dual_issue_core import core_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      issue_valid0,
    input  logic      issue_valid1,
    input  word_t     inst0,
    input  word_t     inst1,
    input  reg_addr_t dbg_addr,
    output logic      ret_valid0,
    output logic      ret_valid1,
    output reg_addr_t ret_addr0,
    output reg_addr_t ret_addr1,
    output word_t     ret_data0,
    output word_t     ret_data1,
    output word_t     dbg_data
);

    // Decode to execute
    logic      d_valid0;
    logic      d_valid1;
    alu_op_t   d_op0;
    alu_op_t   d_op1;
    reg_addr_t d_rj0;
    reg_addr_t d_rj1;
    reg_addr_t d_rk0;
    reg_addr_t d_rk1;
    reg_addr_t d_rd0;
    reg_addr_t d_rd1;
    imm12_t    d_imm0;
    imm12_t    d_imm1;

    // Execute to register file
    reg_addr_t rj0;
    reg_addr_t rk0;
    reg_addr_t rj1;
    reg_addr_t rk1;
    word_t     rrj0;
    word_t     rrk0;
    word_t     rrj1;
    word_t     rrk1;
    logic      ifwb0;
    logic      ifwb1;

    decode_stage u_decode (
        .clk          (clk),
        .rstn         (rstn),
        .issue_valid0 (issue_valid0),
        .issue_valid1 (issue_valid1),
        .inst0        (inst0),
        .inst1        (inst1),
        .d_valid0     (d_valid0),
        .d_valid1     (d_valid1),
        .d_op0        (d_op0),
        .d_op1        (d_op1),
        .d_rj0        (d_rj0),
        .d_rj1        (d_rj1),
        .d_rk0        (d_rk0),
        .d_rk1        (d_rk1),
        .d_rd0        (d_rd0),
        .d_rd1        (d_rd1),
        .d_imm0       (d_imm0),
        .d_imm1       (d_imm1)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rstn       (rstn),
        .d_valid0   (d_valid0),
        .d_valid1   (d_valid1),
        .d_op0      (d_op0),
        .d_op1      (d_op1),
        .d_rj0      (d_rj0),
        .d_rj1      (d_rj1),
        .d_rk0      (d_rk0),
        .d_rk1      (d_rk1),
        .d_rd0      (d_rd0),
        .d_rd1      (d_rd1),
        .d_imm0     (d_imm0),
        .d_imm1     (d_imm1),
        .rrj0       (rrj0),
        .rrk0       (rrk0),
        .rrj1       (rrj1),
        .rrk1       (rrk1),
        .rj0        (rj0),
        .rk0        (rk0),
        .rj1        (rj1),
        .rk1        (rk1),
        .ret_valid0 (ret_valid0),
        .ret_valid1 (ret_valid1),
        .ret_write0 (ifwb0),
        .ret_write1 (ifwb1),
        .ret_addr0  (ret_addr0),
        .ret_addr1  (ret_addr1),
        .ret_data0  (ret_data0),
        .ret_data1  (ret_data1)
    );

    // Retire latch doubles as the write port
    register_file u_regfile (
        .clk      (clk),
        .rstn     (rstn),
        .ifwb0    (ifwb0),
        .ifwb1    (ifwb1),
        .wb_addr0 (ret_addr0),
        .wb_addr1 (ret_addr1),
        .wb_data0 (ret_data0),
        .wb_data1 (ret_data1),
        .rj0      (rj0),
        .rk0      (rk0),
        .rj1      (rj1),
        .rk1      (rk1),
        .dbg_addr (dbg_addr),
        .rrj0     (rrj0),
        .rrk0     (rrk0),
        .rrj1     (rrj1),
        .rrk1     (rrk1),
        .dbg_data (dbg_data)
    );

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20; // 40 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstn = 1'b1; // Released just after an edge
    end

endmodule

//--- dv/core_tb.sv
module core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RETIRE_LIMIT = 4;
    localparam int N_RANDOM     = 40;

    typedef struct packed {
        logic  v0;
        logic  v1;
        word_t i0;
        word_t i1;
    } bundle_t;

    typedef struct packed {
        logic [31:0] cyc; // Cycle the bundle was applied
        logic        v0;
        logic        v1;
        logic        c0;  // Data compared only for known encodings
        logic        c1;
        reg_addr_t   a0;
        reg_addr_t   a1;
        word_t       d0;
        word_t       d1;
    } retire_t;

    logic        clk;
    logic        rstn;
    logic        issue_valid0;
    logic        issue_valid1;
    word_t       inst0;
    word_t       inst1;
    reg_addr_t   dbg_addr;
    logic        ret_valid0;
    logic        ret_valid1;
    reg_addr_t   ret_addr0;
    reg_addr_t   ret_addr1;
    word_t       ret_data0;
    word_t       ret_data1;
    word_t       dbg_data;

    bundle_t     table_q [$];
    retire_t     exp_q [$];
    word_t       model_rf [32];
    integer      seed;
    int unsigned cycle_cnt = 0;

    tb_clock_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    dual_issue_core UUT (
        .clk          (clk),
        .rstn         (rstn),
        .issue_valid0 (issue_valid0),
        .issue_valid1 (issue_valid1),
        .inst0        (inst0),
        .inst1        (inst1),
        .dbg_addr     (dbg_addr),
        .ret_valid0   (ret_valid0),
        .ret_valid1   (ret_valid1),
        .ret_addr0    (ret_addr0),
        .ret_addr1    (ret_addr1),
        .ret_data0    (ret_data0),
        .ret_data1    (ret_data1),
        .dbg_data     (dbg_data)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ##################################################
    // Error reporting
    // ##################################################

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %0h expected %0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // ##################################################
    // Instruction encoding and reference model
    // ##################################################

    function automatic word_t enc_3r(input logic [16:0] opc, input reg_addr_t rd,
                                     input reg_addr_t rj, input reg_addr_t rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic word_t enc_addi(input reg_addr_t rd, input reg_addr_t rj,
                                       input logic [11:0] imm);
        return {OPC_ADDI_W, imm, rj, rd};
    endfunction

    function automatic logic lane_known(input word_t inst);
        logic [16:0] f;
        f = inst[31:15];
        return (inst[31:22] == OPC_ADDI_W) || (f == OPC_ADD_W) || (f == OPC_SUB_W)
            || (f == OPC_SLT) || (f == OPC_SLTU) || (f == OPC_AND) || (f == OPC_OR)
            || (f == OPC_XOR);
    endfunction

    // Result from the model state before the bundle
    function automatic word_t lane_result(input word_t inst);
        word_t a;
        word_t b;
        word_t y;
        a = model_rf[inst[9:5]];
        b = model_rf[inst[14:10]];
        y = '0;
        if (inst[31:22] == OPC_ADDI_W) begin
            y = a + {{20{inst[21]}}, inst[21:10]};
        end else begin
            case (inst[31:15])
                OPC_ADD_W: y = a + b;
                OPC_SUB_W: y = a - b;
                OPC_SLT:   y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OPC_SLTU:  y = (a < b) ? 32'd1 : 32'd0;
                OPC_AND:   y = a & b;
                OPC_OR:    y = a | b;
                OPC_XOR:   y = a ^ b;
                default:   y = '0;
            endcase
        end
        return y;
    endfunction

    task automatic add_entry(input logic v0, input logic v1, input word_t i0, input word_t i1);
        bundle_t b;
        b.v0 = v0;
        b.v1 = v1;
        b.i0 = i0;
        b.i1 = i1;
        table_q.push_back(b);
    endtask

    task automatic make_random_inst(output word_t inst);
        logic [31:0] r;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        r = $random(seed);
        rd = {2'b00, r[2:0]}; // r0..r7 keeps collisions frequent
        rj = {2'b00, r[5:3]};
        rk = {2'b00, r[8:6]};
        case (r[12:9] % 9)
            0:       inst = enc_3r(OPC_ADD_W, rd, rj, rk);
            1:       inst = enc_3r(OPC_SUB_W, rd, rj, rk);
            2:       inst = enc_3r(OPC_SLT, rd, rj, rk);
            3:       inst = enc_3r(OPC_SLTU, rd, rj, rk);
            4:       inst = enc_3r(OPC_AND, rd, rj, rk);
            5:       inst = enc_3r(OPC_OR, rd, rj, rk);
            6:       inst = enc_3r(OPC_XOR, rd, rj, rk);
            7:       inst = enc_addi(rd, rj, r[24:13]);
            default: inst = {17'h1ffff, rk, rj, rd}; // Unknown encoding
        endcase
    endtask

    task automatic build_table();
        logic [31:0] r;
        word_t       i0;
        word_t       i1;
        add_entry(1, 1, enc_addi(1, 0, 12'hffb), enc_addi(2, 0, 12'h007)); // r1 = -5, r2 = 7
        add_entry(1, 1, enc_3r(OPC_SLT, 3, 1, 2), enc_3r(OPC_SLTU, 4, 1, 2));
        add_entry(1, 1, enc_3r(OPC_ADD_W, 5, 3, 4), enc_3r(OPC_SUB_W, 6, 1, 2));
        add_entry(1, 1, enc_3r(OPC_AND, 7, 1, 2), enc_3r(OPC_OR, 3, 1, 6));
        add_entry(1, 1, enc_3r(OPC_XOR, 4, 1, 2), enc_3r(OPC_SLT, 5, 2, 1));
        add_entry(1, 1, enc_addi(6, 6, 12'h800), enc_3r(OPC_SLTU, 7, 2, 1));
        add_entry(1, 1, enc_addi(5, 0, 12'd100), enc_3r(OPC_ADD_W, 6, 5, 0)); // Lane 1 sees old r5
        add_entry(1, 1, enc_addi(20, 0, 12'd1), enc_addi(20, 0, 12'd2));      // Lane 1 wins r20
        add_entry(1, 1, enc_3r(OPC_ADD_W, 21, 20, 0), enc_addi(0, 0, 12'd123));
        add_entry(1, 1, enc_3r(OPC_ADD_W, 22, 0, 0), {17'h1ffff, 5'd1, 5'd2, 5'd23});
        add_entry(0, 0, enc_addi(1, 0, 12'd9), enc_addi(2, 0, 12'd9));       // Idle cycle
        add_entry(1, 0, enc_addi(24, 21, 12'd5), enc_addi(25, 0, 12'd77));
        add_entry(1, 1, {17'h1ffff, 5'd3, 5'd4, 5'd21}, enc_3r(OPC_ADD_W, 26, 21, 22));
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            make_random_inst(i0);
            make_random_inst(i1);
            add_entry(r[1:0] != 2'b00, r[3:2] != 2'b00, i0, i1);
        end
    endtask

    task automatic apply_bundle(input bundle_t b);
        retire_t e;
        word_t   y0;
        word_t   y1;
        y0 = lane_result(b.i0);
        y1 = lane_result(b.i1);
        e.cyc = cycle_cnt;
        e.v0  = b.v0;
        e.v1  = b.v1;
        e.c0  = b.v0 && lane_known(b.i0);
        e.c1  = b.v1 && lane_known(b.i1);
        e.a0  = b.i0[4:0];
        e.a1  = b.i1[4:0];
        e.d0  = y0;
        e.d1  = y1;
        if (e.c0 && (e.a0 != 5'd0)) model_rf[e.a0] = y0; // Lane 0 first, lane 1 last
        if (e.c1 && (e.a1 != 5'd0)) model_rf[e.a1] = y1;
        if (b.v0 || b.v1) exp_q.push_back(e);
        issue_valid0 = b.v0;
        issue_valid1 = b.v1;
        inst0        = b.i0;
        inst1        = b.i1;
    endtask

    // ##################################################
    // Retire monitor
    // ##################################################

    always @(negedge clk) begin
        retire_t e;
        if (rstn === 1'b1) begin
            if (ret_valid0 || ret_valid1) begin
                if (exp_q.size() == 0) begin
                    report_error("Retire seen with no bundle outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_value("ret_valid0", ret_valid0, e.v0);
                    check_value("ret_valid1", ret_valid1, e.v1);
                    if (e.v0) check_value("ret_addr0", ret_addr0, e.a0);
                    if (e.v1) check_value("ret_addr1", ret_addr1, e.a1);
                    if (e.c0) check_value("ret_data0", ret_data0, e.d0);
                    if (e.c1) check_value("ret_data1", ret_data1, e.d1);
                end
            end else if ((exp_q.size() != 0) && (cycle_cnt - exp_q[0].cyc > RETIRE_LIMIT)) begin
                report_error("Retire did not appear within 4 cycles of the bundle");
            end
        end
    end

    // ##################################################
    // Main sequence
    // ##################################################

    initial begin
        int waited;
        issue_valid0 = 1'b0;
        issue_valid1 = 1'b0;
        inst0        = '0;
        inst1        = '0;
        dbg_addr     = '0;
        seed         = 32'h88f6_b70e;
        for (int i = 0; i < 32; i++) model_rf[i] = '0;
        build_table();

        // Stops before the first edge after release, so the reset values are still visible
        waited = 0;
        while (rstn !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 20) report_error("Reset was never released");
        end
        check_value("ret_valid0", ret_valid0, 1'b0);
        check_value("ret_valid1", ret_valid1, 1'b0);

        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #2 dbg_addr = reg_addr_t'(i);
            @(negedge clk);
            check_value("ret_valid0", ret_valid0, 1'b0);
            check_value("ret_valid1", ret_valid1, 1'b0);
            check_value($sformatf("dbg_data[%0d]", i), dbg_data, 32'h0);
        end

        foreach (table_q[k]) begin
            @(posedge clk);
            #2 apply_bundle(table_q[k]);
        end
        @(posedge clk);
        #2;
        issue_valid0 = 1'b0;
        issue_valid1 = 1'b0;

        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > RETIRE_LIMIT + 2) report_error("Pipeline did not drain");
        end

        // Array holds the last bundle from this edge on
        for (int i = 0; i < 32; i++) begin
            if (i != 0) @(posedge clk);
            #2 dbg_addr = reg_addr_t'(i);
            @(negedge clk);
            check_value($sformatf("dbg_data[%0d]", i), dbg_data, model_rf[i]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
logic/core_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/register_file.sv
logic/dual_issue_core.sv
dv/tb_clock_gen.sv
dv/core_tb.sv
